//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_adxl362
RTL_TOP   ?= adxl362
FILELIST  ?= adxl362.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- adxl362.f
hdl/adxl362_pkg.sv
hdl/adxl362_spi_shifter.sv
hdl/adxl362_spi.sv
hdl/adxl362_regs.sv
hdl/adxl362_fifo.sv
hdl/adxl362.sv
verif/clock_gen.sv
verif/tb_adxl362.sv

//--- hdl/adxl362.sv
// ~~~~~~~~~~~~~~~~~~~~
// ADXL362 top level
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module adxl362 (
   input  logic        clk_sys,
   input  logic        nCS,
   input  logic        SCLK,
   input  logic        MOSI,
   output logic        MISO,
   input  logic        sample_push,
   input  logic [15:0] sample_data
);

   logic [adxl362_pkg::ADDR_W-1:0]   address;
   logic [adxl362_pkg::DATA_W-1:0]   data_write;
   logic                             write;
   logic [adxl362_pkg::DATA_W-1:0]   data_read;
   logic [adxl362_pkg::SAMPLE_W-1:0] fifo_head;
   logic                             fifo_empty;
   logic                             read_data_fifo;
   logic [adxl362_pkg::COUNT_W-1:0]  fifo_count;
   logic                             fifo_flush;

   adxl362_spi spi (
      .clk_sys        (clk_sys),
      .nCS            (nCS),
      .SCLK           (SCLK),
      .MOSI           (MOSI),
      .MISO           (MISO),
      .address        (address),
      .data_write     (data_write),
      .write          (write),
      .data_read      (data_read),
      .fifo_head      (fifo_head),
      .fifo_empty     (fifo_empty),
      .read_data_fifo (read_data_fifo)
   );

   adxl362_regs regs (
      .clk_sys    (clk_sys),
      .address    (address),
      .data_write (data_write),
      .write      (write),
      .data_read  (data_read),
      .fifo_count (fifo_count),
      .fifo_flush (fifo_flush)
   );

   // Sample stream from the converter side
   adxl362_fifo #(
      .WIDTH (adxl362_pkg::SAMPLE_W),
      .DEPTH (adxl362_pkg::FIFO_DEPTH)
   ) sample_fifo (
      .clk_sys    (clk_sys),
      .flush      (fifo_flush),
      .write      (sample_push),
      .data_write (sample_data),
      .read       (read_data_fifo),
      .data_read  (fifo_head),
      .empty      (fifo_empty),
      .full       (),
      .count      (fifo_count)
   );

endmodule

`default_nettype wire

//--- hdl/adxl362_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~
// Synchronous FIFO
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module adxl362_fifo #(
   parameter int WIDTH = 16,
   parameter int DEPTH = 16   // Power of two
) (
   input  logic                     clk_sys,
   input  logic                     flush,
   input  logic                     write,
   input  logic [WIDTH-1:0]         data_write,
   input  logic                     read,
   output logic [WIDTH-1:0]         data_read,
   output logic                     empty,
   output logic                     full,
   output logic [$clog2(DEPTH):0]   count
);

   localparam int AW = $clog2(DEPTH);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [AW-1:0]    wr_ptr;
   logic [AW-1:0]    rd_ptr;
   logic             do_write;
   logic             do_read;

   assign empty    = (count == '0);
   assign full     = (count == (AW+1)'(DEPTH));
   assign do_write = write && !full;    // Push while full is dropped
   assign do_read  = read && !empty;

   always_ff @(posedge clk_sys) begin
      if (flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_write) wr_ptr <= wr_ptr + 1'b1;
         if (do_read)  rd_ptr <= rd_ptr + 1'b1;
         if (do_write && !do_read) begin
            count <= count + 1'b1;
         end else if (do_read && !do_write) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_sys) begin
      if (do_write) mem[wr_ptr] <= data_write;
   end

   assign data_read = mem[rd_ptr];   // Head, no read latency

endmodule

`default_nettype wire

//--- hdl/adxl362_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// ADXL362 shared definitions
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package adxl362_pkg;

   localparam int ADDR_W     = 6;
   localparam int DATA_W     = 8;
   localparam int SAMPLE_W   = 16;
   localparam int FIFO_DEPTH = 16;
   localparam int COUNT_W    = 5;   // Holds 0 up to FIFO_DEPTH

   // SPI command byte
   typedef enum logic [7:0] {
      CMD_WRITE = 8'h0A,
      CMD_READ  = 8'h0B,
      CMD_FIFO  = 8'h0D
   } command_t;

   typedef enum logic [3:0] {
      ST_IDLE,        // Waiting for command byte
      ST_ADDR,
      ST_WR_DATA,
      ST_WR_STROBE,
      ST_RD_RESP,
      ST_FIFO_LO,
      ST_FIFO_HI,
      ST_FIFO_POP,
      ST_DISCARD      // Unknown command, ignore rest of transaction
   } spi_state_t;

   localparam logic [ADDR_W-1:0] REG_DEVID_AD     = 6'h00;
   localparam logic [ADDR_W-1:0] REG_DEVID_MST    = 6'h01;
   localparam logic [ADDR_W-1:0] REG_PARTID       = 6'h02;
   localparam logic [ADDR_W-1:0] REG_FIFO_ENTRIES = 6'h0C;
   localparam logic [ADDR_W-1:0] REG_SOFT_RESET   = 6'h1F;
   localparam logic [ADDR_W-1:0] REG_CTRL_BASE    = 6'h20;  // Runs up to 0x2F

   localparam logic [DATA_W-1:0] ID_AD          = 8'hAD;
   localparam logic [DATA_W-1:0] ID_MST         = 8'h1D;
   localparam logic [DATA_W-1:0] ID_PART        = 8'hF2;
   localparam logic [DATA_W-1:0] SOFT_RESET_KEY = 8'h52;

endpackage

`default_nettype wire

//--- hdl/adxl362_regs.sv
// ~~~~~~~~~~~~~~~~~~~~
// ADXL362 register file
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module adxl362_regs (
   input  logic       clk_sys,
   input  logic [5:0] address,
   input  logic [7:0] data_write,
   input  logic       write,
   output logic [7:0] data_read,
   input  logic [4:0] fifo_count,
   output logic       fifo_flush
);

   logic [7:0] ctrl [16];
   logic       in_ctrl;

   // 0x20 to 0x2F
   assign in_ctrl = (address[5:4] == adxl362_pkg::REG_CTRL_BASE[5:4]);

   assign fifo_flush = write &&
                       (address == adxl362_pkg::REG_SOFT_RESET) &&
                       (data_write == adxl362_pkg::SOFT_RESET_KEY);

   always_ff @(posedge clk_sys) begin
      if (fifo_flush) begin
         ctrl <= '{default: 8'h00};
      end else if (write && in_ctrl) begin
         ctrl[address[3:0]] <= data_write;
      end
   end

   always_comb begin
      case (address)
         adxl362_pkg::REG_DEVID_AD:  data_read = adxl362_pkg::ID_AD;
         adxl362_pkg::REG_DEVID_MST: data_read = adxl362_pkg::ID_MST;
         adxl362_pkg::REG_PARTID:    data_read = adxl362_pkg::ID_PART;
         adxl362_pkg::REG_FIFO_ENTRIES: begin
            data_read = {{(adxl362_pkg::DATA_W - adxl362_pkg::COUNT_W){1'b0}},
                         fifo_count};
         end
         default: begin
            data_read = in_ctrl ? ctrl[address[3:0]] : 8'h00;   // Unmapped reads zero
         end
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/adxl362_spi.sv
// ~~~~~~~~~~~~~~~~~~~~
// SPI command sequencer
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module adxl362_spi (
   input  logic        clk_sys,
   input  logic        nCS,
   input  logic        SCLK,
   input  logic        MOSI,
   output logic        MISO,
   output logic [5:0]  address,
   output logic [7:0]  data_write,
   output logic        write,
   input  logic [7:0]  data_read,
   input  logic [15:0] fifo_head,
   input  logic        fifo_empty,
   output logic        read_data_fifo
);

   logic [7:0]              rx_byte;
   logic                    byte_done;
   logic [7:0]              tx_byte;
   logic                    tx_load;
   adxl362_pkg::spi_state_t state;
   adxl362_pkg::command_t   command;
   logic                    fifo_valid;   // Head present when low byte went out

   adxl362_spi_shifter shifter (
      .clk_sys   (clk_sys),
      .nCS       (nCS),
      .SCLK      (SCLK),
      .MOSI      (MOSI),
      .MISO      (MISO),
      .rx_byte   (rx_byte),
      .byte_done (byte_done),
      .tx_byte   (tx_byte),
      .tx_load   (tx_load)
   );

   // Byte offered to the shifter in each response state
   always_comb begin
      case (state)
         adxl362_pkg::ST_RD_RESP: tx_byte = data_read;
         adxl362_pkg::ST_FIFO_LO: tx_byte = fifo_empty ? 8'h00 : fifo_head[7:0];
         adxl362_pkg::ST_FIFO_HI: tx_byte = fifo_valid ? fifo_head[15:8] : 8'h00;
         default:                 tx_byte = 8'h00;
      endcase
   end

   assign write          = (state == adxl362_pkg::ST_WR_STROBE);
   assign read_data_fifo = (state == adxl362_pkg::ST_FIFO_POP);

   always_ff @(posedge clk_sys or posedge nCS) begin
      if (nCS) begin
         state      <= adxl362_pkg::ST_IDLE;
         tx_load    <= 1'b0;
         address    <= 6'd0;
         fifo_valid <= 1'b0;
      end else begin
         tx_load <= 1'b0;
         case (state)
            adxl362_pkg::ST_IDLE: begin
               if (byte_done) begin
                  case (rx_byte)
                     adxl362_pkg::CMD_WRITE,
                     adxl362_pkg::CMD_READ: begin
                        state <= adxl362_pkg::ST_ADDR;
                     end
                     adxl362_pkg::CMD_FIFO: begin
                        state   <= adxl362_pkg::ST_FIFO_LO;
                        tx_load <= 1'b1;
                     end
                     default: begin
                        state <= adxl362_pkg::ST_DISCARD;
                     end
                  endcase
               end
            end
            adxl362_pkg::ST_ADDR: begin
               if (byte_done) begin
                  address <= rx_byte[5:0];
                  if (command == adxl362_pkg::CMD_WRITE) begin
                     state <= adxl362_pkg::ST_WR_DATA;
                  end else begin
                     state   <= adxl362_pkg::ST_RD_RESP;
                     tx_load <= 1'b1;
                  end
               end
            end
            adxl362_pkg::ST_WR_DATA: begin
               if (byte_done) state <= adxl362_pkg::ST_WR_STROBE;
            end
            adxl362_pkg::ST_WR_STROBE: begin
               address <= address + 6'd1;   // Wraps at 63
               state   <= adxl362_pkg::ST_WR_DATA;
            end
            adxl362_pkg::ST_RD_RESP: begin
               if (byte_done) begin
                  address <= address + 6'd1;
                  tx_load <= 1'b1;
               end
            end
            adxl362_pkg::ST_FIFO_LO: begin
               if (tx_load) fifo_valid <= ~fifo_empty;
               if (byte_done) begin
                  state   <= adxl362_pkg::ST_FIFO_HI;
                  tx_load <= 1'b1;
               end
            end
            adxl362_pkg::ST_FIFO_HI: begin
               if (byte_done) begin
                  if (fifo_valid) begin
                     state <= adxl362_pkg::ST_FIFO_POP;
                  end else begin
                     state   <= adxl362_pkg::ST_FIFO_LO;   // Empty, nothing to pop
                     tx_load <= 1'b1;
                  end
               end
            end
            adxl362_pkg::ST_FIFO_POP: begin
               state   <= adxl362_pkg::ST_FIFO_LO;
               tx_load <= 1'b1;
            end
            default: begin
               state <= adxl362_pkg::ST_DISCARD;   // Hold until nCS rises
            end
         endcase
      end
   end

   // Command and write data
   always_ff @(posedge clk_sys) begin
      if ((state == adxl362_pkg::ST_IDLE) && byte_done) begin
         command <= adxl362_pkg::command_t'(rx_byte);
      end
      if ((state == adxl362_pkg::ST_WR_DATA) && byte_done) begin
         data_write <= rx_byte;
      end
   end

endmodule

`default_nettype wire

//--- hdl/adxl362_spi_shifter.sv
// ~~~~~~~~~~~~~~~~~~~~
// SPI mode 0 shifter
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module adxl362_spi_shifter (
   input  logic       clk_sys,
   input  logic       nCS,
   input  logic       SCLK,
   input  logic       MOSI,
   output logic       MISO,
   output logic [7:0] rx_byte,
   output logic       byte_done,
   input  logic [7:0] tx_byte,
   input  logic       tx_load
);

   logic [1:0] sclk_sync;
   logic [1:0] mosi_sync;
   logic       sclk_prev;
   logic       sclk_rise;
   logic       sclk_fall;
   logic [2:0] bit_cnt;
   logic [7:0] rx_shift;
   logic [7:0] tx_shift;

   // Two flop synchronizers, SCLK idles low in mode 0
   always_ff @(posedge clk_sys or posedge nCS) begin
      if (nCS) begin
         sclk_sync <= 2'b00;
         mosi_sync <= 2'b00;
         sclk_prev <= 1'b0;
      end else begin
         sclk_sync <= {sclk_sync[0], SCLK};
         mosi_sync <= {mosi_sync[0], MOSI};
         sclk_prev <= sclk_sync[1];
      end
   end

   assign sclk_rise = sclk_sync[1] & ~sclk_prev;
   assign sclk_fall = ~sclk_sync[1] & sclk_prev;

   always_ff @(posedge clk_sys or posedge nCS) begin
      if (nCS) begin
         bit_cnt   <= 3'd0;
         rx_shift  <= 8'h00;
         tx_shift  <= 8'h00;
         byte_done <= 1'b0;
      end else begin
         byte_done <= sclk_rise && (bit_cnt == 3'd7);
         if (sclk_rise) begin
            rx_shift <= {rx_shift[6:0], mosi_sync[1]};
            bit_cnt  <= bit_cnt + 3'd1;
         end
         if (tx_load) begin
            tx_shift <= tx_byte;
         end else if (sclk_fall && (bit_cnt != 3'd0)) begin
            // Fall after the last bit of a byte keeps the next MSB in place
            tx_shift <= {tx_shift[6:0], 1'b0};
         end
      end
   end

   assign rx_byte = rx_shift;
   assign MISO    = tx_shift[7];

endmodule

`default_nettype wire

//--- verif/clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench clock
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
   parameter int PERIOD_NS = 4
) (
   output logic clk_sys
);

   initial clk_sys = 1'b0;

   always #(PERIOD_NS / 2) clk_sys = ~clk_sys;

endmodule

`default_nettype wire

//--- verif/tb_adxl362.sv
// ~~~~~~~~~~~~~~~~~~~~
// ADXL362 testbench
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_adxl362;

   localparam int CLK_PERIOD_NS = 4;
   localparam int HALF_CYCLES   = 8;                    // SCLK half period in clk_sys cycles
   localparam int BYTE_CYCLES   = 16 * HALF_CYCLES;
   localparam int TXN_CYCLES    = 4 + 2 * HALF_CYCLES;  // Chip select setup and hold
   // About 100 bytes in 21 transactions over all tests
   localparam int TEST_CYCLES   = 100 * BYTE_CYCLES + 21 * TXN_CYCLES + 64;
   localparam int TIMEOUT_NS    = 2 * TEST_CYCLES * CLK_PERIOD_NS;

   logic                              clk_sys;
   logic                              nCS;
   logic                              SCLK;
   logic                              MOSI;
   logic                              MISO;
   logic                              sample_push;
   logic [adxl362_pkg::SAMPLE_W-1:0]  sample_data;

   integer                            seed = 71;
   int                                byte_errors = 0;
   int                                sample_errors = 0;
   logic [adxl362_pkg::DATA_W-1:0]    wr_buf [16];
   logic [adxl362_pkg::DATA_W-1:0]    rd_buf [16];
   logic [adxl362_pkg::SAMPLE_W-1:0]  sample_buf [20];

   clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) clk_gen (.clk_sys(clk_sys));

   adxl362 dut (
      .clk_sys     (clk_sys),
      .nCS         (nCS),
      .SCLK        (SCLK),
      .MOSI        (MOSI),
      .MISO        (MISO),
      .sample_push (sample_push),
      .sample_data (sample_data)
   );

   task automatic check_byte(input logic [adxl362_pkg::DATA_W-1:0] got,
                             input logic [adxl362_pkg::DATA_W-1:0] exp, input string msg);
      if (got !== exp) begin
         $display("error %0t ns: %s got %h expected %h", $time, msg, got, exp);
         byte_errors++;
      end
   endtask

   task automatic check_sample(input logic [adxl362_pkg::SAMPLE_W-1:0] got,
                               input logic [adxl362_pkg::SAMPLE_W-1:0] exp, input string msg);
      if (got !== exp) begin
         $display("error %0t ns: %s got %h expected %h", $time, msg, got, exp);
         sample_errors++;
      end
   endtask

   // Bus changes land 1 ns after the clock edge
   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk_sys);
      #1;
   endtask

   // Mode 0 master, MISO captured on the rising SCLK edge
   task automatic spi_xfer(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
      rx = 8'h00;
      for (int i = 0; i < nbits; i++) begin
         MOSI = tx[7 - i];
         wait_cycles(HALF_CYCLES);
         SCLK = 1'b1;
         rx   = {rx[6:0], MISO};
         wait_cycles(HALF_CYCLES);
         SCLK = 1'b0;
      end
   endtask

   task automatic cs_begin();
      nCS = 1'b0;
      wait_cycles(4);
   endtask

   task automatic cs_end();
      wait_cycles(HALF_CYCLES);   // Lets the last write strobe or pop go out
      nCS = 1'b1;
      wait_cycles(HALF_CYCLES);
   endtask

   task automatic reg_write(input logic [5:0] addr, input int n);
      logic [7:0] rx;
      cs_begin();
      spi_xfer(adxl362_pkg::CMD_WRITE, 8, rx);
      spi_xfer({2'b00, addr}, 8, rx);
      for (int k = 0; k < n; k++) spi_xfer(wr_buf[k], 8, rx);
      cs_end();
   endtask

   task automatic reg_read(input logic [5:0] addr, input int n);
      logic [7:0] rx;
      cs_begin();
      spi_xfer(adxl362_pkg::CMD_READ, 8, rx);
      spi_xfer({2'b00, addr}, 8, rx);
      for (int k = 0; k < n; k++) spi_xfer(8'h00, 8, rd_buf[k]);
      cs_end();
   endtask

   task automatic fifo_read(input int n);
      logic [7:0] lo;
      logic [7:0] hi;
      cs_begin();
      spi_xfer(adxl362_pkg::CMD_FIFO, 8, lo);
      for (int k = 0; k < n; k++) begin
         spi_xfer(8'h00, 8, lo);
         spi_xfer(8'h00, 8, hi);
         sample_buf[k] = {hi, lo};
      end
      cs_end();
   endtask

   task automatic write_one(input logic [5:0] addr, input logic [7:0] data);
      wr_buf[0] = data;
      reg_write(addr, 1);
   endtask

   task automatic expect_reg(input logic [5:0] addr, input logic [7:0] exp, input string msg);
      reg_read(addr, 1);
      check_byte(rd_buf[0], exp, msg);
   endtask

   task automatic push_sample(input logic [15:0] value);
      sample_data = value;
      sample_push = 1'b1;
      wait_cycles(1);
      sample_push = 1'b0;
   endtask

   task automatic soft_reset();
      write_one(adxl362_pkg::REG_SOFT_RESET, adxl362_pkg::SOFT_RESET_KEY);
   endtask

   task automatic id_read_burst();
      reg_read(adxl362_pkg::REG_DEVID_AD, 3);
      check_byte(rd_buf[0], 8'hAD, "DEVID_AD");
      check_byte(rd_buf[1], 8'h1D, "DEVID_MST");
      check_byte(rd_buf[2], 8'hF2, "PARTID");
   endtask

   task automatic write_burst_wrap();
      for (int k = 0; k < 4; k++) wr_buf[k] = 8'($random(seed));
      reg_write(6'h2E, 4);
      reg_read(6'h2E, 3);
      check_byte(rd_buf[0], wr_buf[0], "ctrl 0x2E");
      check_byte(rd_buf[1], wr_buf[1], "ctrl 0x2F");
      check_byte(rd_buf[2], 8'h00, "read-only 0x30");
      write_one(adxl362_pkg::REG_DEVID_AD, 8'h5A);
      expect_reg(adxl362_pkg::REG_DEVID_AD, 8'hAD, "DEVID_AD after write");
   endtask

   task automatic fifo_stream();
      logic [15:0] model [$];
      logic [15:0] value;
      int          n;
      for (int k = 0; k < adxl362_pkg::FIFO_DEPTH + 2; k++) begin
         value = 16'($random(seed));
         push_sample(value);
         if (model.size() < adxl362_pkg::FIFO_DEPTH) model.push_back(value);
      end
      expect_reg(adxl362_pkg::REG_FIFO_ENTRIES, 8'(model.size()), "entries when full");
      fifo_read(10);
      for (int k = 0; k < 10; k++) check_sample(sample_buf[k], model.pop_front(), "FIFO sample");
      expect_reg(adxl362_pkg::REG_FIFO_ENTRIES, 8'(model.size()), "entries after 10 reads");
      n = model.size();
      fifo_read(n + 1);
      for (int k = 0; k < n; k++) check_sample(sample_buf[k], model.pop_front(), "FIFO sample");
      check_sample(sample_buf[n], 16'h0000, "read past empty");
      expect_reg(adxl362_pkg::REG_FIFO_ENTRIES, 8'h00, "entries when drained");
   endtask

   task automatic soft_reset_clears();
      write_one(6'h25, 8'hC3);
      for (int k = 0; k < 3; k++) push_sample(16'($random(seed)));
      expect_reg(6'h25, 8'hC3, "ctrl 0x25 before soft reset");
      soft_reset();
      expect_reg(6'h25, 8'h00, "ctrl 0x25 after soft reset");
      expect_reg(adxl362_pkg::REG_FIFO_ENTRIES, 8'h00, "entries after soft reset");
   endtask

   task automatic abort_and_unknown_cmd();
      logic [7:0] rx;
      write_one(6'h24, 8'h3C);
      cs_begin();
      spi_xfer(adxl362_pkg::CMD_WRITE, 8, rx);
      spi_xfer(8'h24, 8, rx);
      spi_xfer(8'hFF, 4, rx);   // nCS rises halfway through the data byte
      cs_end();
      expect_reg(6'h24, 8'h3C, "ctrl 0x24 after aborted write");
      cs_begin();
      spi_xfer(8'h55, 8, rx);
      check_byte(rx, 8'h00, "MISO on unknown command");
      spi_xfer(8'h24, 8, rx);
      check_byte(rx, 8'h00, "MISO after unknown command");
      spi_xfer(8'h99, 8, rx);
      check_byte(rx, 8'h00, "MISO after unknown command");
      cs_end();
      expect_reg(6'h24, 8'h3C, "ctrl 0x24 after unknown command");
   endtask

   initial begin
      nCS         = 1'b1;
      SCLK        = 1'b0;
      MOSI        = 1'b0;
      sample_push = 1'b0;
      sample_data = '0;
      wait_cycles(16);
      soft_reset();
      id_read_burst();
      write_burst_wrap();
      fifo_stream();
      soft_reset_clears();
      abort_and_unknown_cmd();
      $display("tests done with %0d byte errors and %0d sample errors",
               byte_errors, sample_errors);
      if (byte_errors + sample_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("watchdog timeout, the tests did not finish in time");
      $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire
